// File: verilog/tank_macros.svh
// enemy tank unit shared constants
// field size, spawn corner bits, direction codes and widths
`ifndef TANK_MACROS_SVH
`define TANK_MACROS_SVH

// field ------------------------------------------
`define TANK_X_MAX 24 // last column
`define TANK_Y_MAX 12 // last row

// widths -----------------------------------------
`define TANK_COORD_W 5 // one cell coordinate
`define TANK_DIR_W 2
`define TANK_SCORE_W 5 // kill count, wraps
`define TANK_CREDIT_W 2

`define TANK_SHELL_SLOTS 2 // shell slots, also the initial credits
`define TANK_CORNER_RIGHT 0 // spawn_corner bit picking the last column
`define TANK_CORNER_BOTTOM 1 // spawn_corner bit picking the last row

`define TANK_DIR_UP 2'b00 // y falls
`define TANK_DIR_DOWN 2'b01 // y rises
`define TANK_DIR_LEFT 2'b10 // x falls
`define TANK_DIR_RIGHT 2'b11 // x rises

`endif

// File: verilog/tank_pkg.sv
// enemy tank unit types
// coordinates, distances, headings, score, credits and the life-cycle states
`include "tank_macros.svh"

package tank_pkg;

	//--------------------------------------------------
	// plain vectors with a meaning
	//--------------------------------------------------
	typedef logic [`TANK_COORD_W-1:0] coord_t; // cell column or row
	typedef logic [`TANK_COORD_W-1:0] dist_t; // absolute gap along one axis
	typedef logic [`TANK_DIR_W-1:0] dir_t; // heading, see TANK_DIR_*
	typedef logic [`TANK_SCORE_W-1:0] score_t; // kills, wrapping
	typedef logic [`TANK_CREDIT_W-1:0] credit_t; // shell credits or busy slots

	//--------------------------------------------------
	// enemy life cycle
	//--------------------------------------------------
	typedef enum logic [1:0]
	{
		EN_IDLE, // never spawned since clear
		EN_ALIVE, // on the field, hunting
		EN_DEAD // killed, waits for spawn
	} enemy_state_t;

endpackage

// File: verilog/tank_ifs.sv
// enemy tank unit internal interfaces
// pursuit_if carries the registered distances from the pursuit calculator,
// fire_if carries shots and returned credits between controller and shells
`timescale 1ns/1ps

interface pursuit_if import tank_pkg::*;
	;
	logic eql; // enemy and player share a cell
	dist_t h_dis; // gap along x
	dist_t v_dis; // gap along y
	logic player_right; // player x above enemy x
	logic player_below; // player y above enemy y

	modport calc
	(
		output eql, h_dis, v_dis, player_right, player_below
	);

	// side flags give the shot heading
	modport ctrl
	(
		input eql, h_dis, v_dis, player_right, player_below
	);

	modport mover
	(
		input h_dis, v_dis, player_right, player_below
	);
endinterface

interface fire_if import tank_pkg::*;
	;
	logic fire; // one-cycle shot, only with credit left
	coord_t fire_x; // enemy cell before the step
	coord_t fire_y;
	dir_t fire_dir; // toward the player
	logic credit; // one slot freed

	modport ctrl (output fire, fire_x, fire_y, fire_dir, input credit);
	modport engine (input fire, fire_x, fire_y, fire_dir, output credit);
endinterface

// File: verilog/pursuit_calc.sv
// pursuit calculator
// registers the per-axis gap between the enemy and the player tank,
// which side the player is on and whether both share one cell
`timescale 1ns/1ps

module pursuit_calc import tank_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic enable, // low clears all results
	input coord_t eny_x,
	input coord_t eny_y,
	input coord_t my_x, // player tank
	input coord_t my_y,
	pursuit_if.calc pv
);

	logic right_c; // player further right
	logic below_c; // player further down

	assign right_c = (my_x > eny_x);
	assign below_c = (my_y > eny_y);

	//--------------------------------------------------
	// one cycle behind the positions
	//--------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pv.eql <= 1'b0;
			pv.h_dis <= '0;
			pv.v_dis <= '0;
			pv.player_right <= 1'b0;
			pv.player_below <= 1'b0;
		end
		else if (!enable)
		begin
			pv.eql <= 1'b0;
			pv.h_dis <= '0;
			pv.v_dis <= '0;
			pv.player_right <= 1'b0;
			pv.player_below <= 1'b0;
		end
		else
		begin
			pv.eql <= (eny_x == my_x) && (eny_y == my_y); // same cell
			pv.h_dis <= right_c ? dist_t'(my_x - eny_x) : dist_t'(eny_x - my_x);
			pv.v_dis <= below_c ? dist_t'(my_y - eny_y) : dist_t'(eny_y - my_y);
			pv.player_right <= right_c;
			pv.player_below <= below_c;
		end
	end

endmodule

// File: verilog/tank_mover.sv
// enemy tank mover
// holds the enemy position and heading, places the tank at a corner on load
// and steps it one cell toward the player on advance
`timescale 1ns/1ps
`include "tank_macros.svh"

module tank_mover import tank_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic enable,
	input logic load, // place at corner
	input logic advance, // one move allowed
	input logic [1:0] load_corner,
	pursuit_if.mover pv,
	output coord_t eny_x,
	output coord_t eny_y,
	output dir_t eny_dir
);

	logic move_x; // step along x this time
	dir_t next_dir;
	coord_t next_x;
	coord_t next_y;

	//--------------------------------------------------
	// step rule
	//--------------------------------------------------
	always_comb
	begin
		// aligned on one axis closes the other, else shrink the smaller gap
		move_x = (pv.v_dis == '0) || ((pv.h_dis != '0) && (pv.h_dis < pv.v_dis));
		if (move_x)
			next_dir = pv.player_right ? `TANK_DIR_RIGHT : `TANK_DIR_LEFT;
		else
			next_dir = pv.player_below ? `TANK_DIR_DOWN : `TANK_DIR_UP;

		next_x = eny_x; // stays put at the field edge
		next_y = eny_y;
		case (next_dir)
			`TANK_DIR_UP:
				if (eny_y != '0)
					next_y = eny_y - 1'b1;
			`TANK_DIR_DOWN:
				if (eny_y != coord_t'(`TANK_Y_MAX))
					next_y = eny_y + 1'b1;
			`TANK_DIR_LEFT:
				if (eny_x != '0)
					next_x = eny_x - 1'b1;
			default:
				if (eny_x != coord_t'(`TANK_X_MAX))
					next_x = eny_x + 1'b1;
		endcase
	end

	//--------------------------------------------------
	// position and heading
	//--------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			eny_x <= '0;
			eny_y <= '0;
			eny_dir <= `TANK_DIR_UP;
		end
		else if (!enable)
		begin
			eny_x <= '0;
			eny_y <= '0;
			eny_dir <= `TANK_DIR_UP;
		end
		else if (load)
		begin
			eny_x <= load_corner[`TANK_CORNER_RIGHT] ? coord_t'(`TANK_X_MAX) : '0;
			eny_y <= load_corner[`TANK_CORNER_BOTTOM] ? coord_t'(`TANK_Y_MAX) : '0;
			eny_dir <= `TANK_DIR_UP; // fresh tank faces up
		end
		else if (advance)
		begin
			eny_x <= next_x;
			eny_y <= next_y;
			eny_dir <= next_dir; // turns even when blocked
		end
	end

endmodule

// File: verilog/shell_engine.sv
// enemy shell engine
// keeps the shell slots, flies each busy shell one cell per step,
// retires shells that strike the player or leave the field and
// hands one credit per retired shell back to the controller
`timescale 1ns/1ps
`include "tank_macros.svh"

module shell_engine import tank_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic enable,
	input logic step, // game timebase pulse
	input coord_t my_x, // player tank
	input coord_t my_y,
	fire_if.engine fv,
	output logic player_hit, // strike pulse alongside the credit
	output credit_t shells_active // busy slots
);

	logic [`TANK_SHELL_SLOTS-1:0] busy; // slot holds a shell
	logic [`TANK_SHELL_SLOTS-1:0] pend; // ended, waits for its credit
	logic [`TANK_SHELL_SLOTS-1:0] hit; // ended on the player
	logic [`TANK_SHELL_SLOTS-1:0] off; // next move leaves the field
	logic [`TANK_SHELL_SLOTS-1:0] strike; // next cell is the player
	logic [`TANK_SHELL_SLOTS-1:0] free_oh; // lowest free slot
	logic [`TANK_SHELL_SLOTS-1:0] ret_oh; // lowest ended slot
	coord_t sx [`TANK_SHELL_SLOTS];
	coord_t sy [`TANK_SHELL_SLOTS];
	coord_t nx [`TANK_SHELL_SLOTS];
	coord_t ny [`TANK_SHELL_SLOTS];
	dir_t sdir [`TANK_SHELL_SLOTS];

	//--------------------------------------------------
	// next cell per slot
	//--------------------------------------------------
	always_comb
	begin
		for (int i = 0; i < `TANK_SHELL_SLOTS; i++)
		begin
			nx[i] = sx[i];
			ny[i] = sy[i];
			case (sdir[i])
				`TANK_DIR_UP:
				begin
					off[i] = (sy[i] == '0); // top row
					ny[i] = sy[i] - 1'b1;
				end
				`TANK_DIR_DOWN:
				begin
					off[i] = (sy[i] == coord_t'(`TANK_Y_MAX)); // bottom row
					ny[i] = sy[i] + 1'b1;
				end
				`TANK_DIR_LEFT:
				begin
					off[i] = (sx[i] == '0);
					nx[i] = sx[i] - 1'b1;
				end
				default:
				begin
					off[i] = (sx[i] == coord_t'(`TANK_X_MAX));
					nx[i] = sx[i] + 1'b1;
				end
			endcase
			strike[i] = (nx[i] == my_x) && (ny[i] == my_y);
		end
	end

	assign free_oh = ~busy & (busy + 1'b1); // lowest zero bit
	assign ret_oh = (busy & pend) & (~(busy & pend) + 1'b1); // lowest set bit in slot order
	assign fv.credit = |ret_oh; // at most one per cycle
	assign player_hit = |(ret_oh & hit);

	always_comb
	begin
		shells_active = '0;
		for (int i = 0; i < `TANK_SHELL_SLOTS; i++)
			shells_active = shells_active + credit_t'(busy[i]);
	end

	//--------------------------------------------------
	// slot control
	//--------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= '0;
			pend <= '0;
			hit <= '0;
		end
		else if (!enable)
		begin
			busy <= '0;
			pend <= '0;
			hit <= '0;
		end
		else
		begin
			for (int i = 0; i < `TANK_SHELL_SLOTS; i++)
			begin
				if (ret_oh[i])
				begin
					busy[i] <= 1'b0; // credit leaves this cycle
					pend[i] <= 1'b0;
				end
				else if (fv.fire && free_oh[i])
				begin
					busy[i] <= 1'b1; // claimed and flies from the next step
					pend[i] <= 1'b0;
					hit[i] <= 1'b0;
				end
				else if (step && busy[i] && !pend[i] && (off[i] || strike[i]))
				begin
					pend[i] <= 1'b1;
					hit[i] <= !off[i]; // exit beats a wrapped match
				end
			end
		end
	end

	// shell payload
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `TANK_SHELL_SLOTS; i++)
		begin
			if (fv.fire && free_oh[i])
			begin
				sx[i] <= fv.fire_x;
				sy[i] <= fv.fire_y;
				sdir[i] <= fv.fire_dir;
			end
			else if (step && busy[i] && !pend[i] && !off[i])
			begin
				sx[i] <= nx[i]; // one cell per step
				sy[i] <= ny[i];
			end
		end
	end

endmodule

// File: verilog/enemy_ctrl.sv
// enemy tank controller
// runs the life cycle, detects kills by collision or player bullet,
// counts the score, keeps the shell credits and decides moves and shots
`timescale 1ns/1ps
`include "tank_macros.svh"

module enemy_ctrl import tank_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic enable,
	input logic spawn, // request a new tank
	input logic step, // game timebase pulse
	input logic mybul_valid, // player bullet in flight
	input logic [1:0] spawn_corner,
	input coord_t mybul_x,
	input coord_t mybul_y,
	input coord_t eny_x,
	input coord_t eny_y,
	pursuit_if.ctrl pv,
	fire_if.ctrl fv,
	output logic load,
	output logic advance,
	output logic [1:0] load_corner,
	output logic eny_alive,
	output score_t score
);

	enemy_state_t state;
	credit_t credits; // free shell slots
	logic pv_stale; // pursuit data still from the old position
	logic bullet_on_eny; // player bullet on our cell
	logic kill;
	logic act; // alive and free to move or shoot
	logic aligned; // exactly one gap is zero

	//--------------------------------------------------
	// decisions
	//--------------------------------------------------
	assign bullet_on_eny = mybul_valid && (mybul_x == eny_x) && (mybul_y == eny_y);
	assign kill = (state == EN_ALIVE) && ((pv.eql && !pv_stale) || bullet_on_eny);
	assign act = (state == EN_ALIVE) && !pv_stale && !kill; // kill covers eql
	assign aligned = (pv.h_dis == '0) != (pv.v_dis == '0);

	assign load = enable && spawn && (state != EN_ALIVE);
	assign load_corner = spawn_corner;
	assign advance = step && act;
	assign eny_alive = (state == EN_ALIVE);

	// shot leaves from the cell before the step
	assign fv.fire = step && act && aligned && (credits != '0);
	assign fv.fire_x = eny_x;
	assign fv.fire_y = eny_y;
	assign fv.fire_dir = (pv.h_dis == '0) ?
		(pv.player_below ? `TANK_DIR_DOWN : `TANK_DIR_UP) :
		(pv.player_right ? `TANK_DIR_RIGHT : `TANK_DIR_LEFT);

	//--------------------------------------------------
	// life cycle, score and credits
	//--------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= EN_IDLE;
			score <= '0;
			credits <= credit_t'(`TANK_SHELL_SLOTS); // all slots free
			pv_stale <= 1'b0;
		end
		else if (!enable)
		begin
			state <= EN_IDLE;
			score <= '0;
			credits <= credit_t'(`TANK_SHELL_SLOTS);
			pv_stale <= 1'b0;
		end
		else
		begin
			pv_stale <= load; // one cycle for the pursuit registers
			credits <= credits + credit_t'(fv.credit) - credit_t'(fv.fire);
			case (state)
				EN_IDLE, EN_DEAD:
					if (load)
						state <= EN_ALIVE;
				EN_ALIVE:
					if (kill)
					begin
						state <= EN_DEAD;
						score <= score + 1'b1; // wraps
					end
				default:
					state <= EN_IDLE;
			endcase
		end
	end

endmodule

// File: verilog/enemy_tank_top.sv
// enemy tank unit top level
// one enemy tank that spawns at a corner, hunts the player tank one cell
// per game step, fires along rows and columns and counts its own deaths
`timescale 1ns/1ps

module enemy_tank_top import tank_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic enable, // low clears the whole unit
	input logic spawn,
	input logic step, // one-cycle game timebase
	input logic mybul_valid,
	input logic [1:0] spawn_corner,
	input coord_t my_x, // player tank
	input coord_t my_y,
	input coord_t mybul_x, // player bullet
	input coord_t mybul_y,
	output coord_t eny_x,
	output coord_t eny_y,
	output dir_t eny_dir,
	output logic eny_alive,
	output logic player_hit,
	output score_t score,
	output credit_t shells_active
);

	logic load;
	logic advance;
	logic [1:0] load_corner;

	pursuit_if pv ();
	fire_if fv ();

	//--------------------------------------------------
	// blocks
	//--------------------------------------------------
	pursuit_calc i_pursuit_calc
	(
		.clk(clk), .rst_n(rst_n), .enable(enable),
		.eny_x(eny_x), .eny_y(eny_y), .my_x(my_x), .my_y(my_y),
		.pv(pv.calc)
	);

	tank_mover i_tank_mover
	(
		.clk(clk), .rst_n(rst_n), .enable(enable),
		.load(load), .advance(advance), .load_corner(load_corner),
		.pv(pv.mover),
		.eny_x(eny_x), .eny_y(eny_y), .eny_dir(eny_dir)
	);

	shell_engine i_shell_engine
	(
		.clk(clk), .rst_n(rst_n), .enable(enable), .step(step),
		.my_x(my_x), .my_y(my_y), .fv(fv.engine),
		.player_hit(player_hit), .shells_active(shells_active)
	);

	enemy_ctrl i_enemy_ctrl
	(
		.clk(clk), .rst_n(rst_n), .enable(enable), .spawn(spawn), .step(step),
		.mybul_valid(mybul_valid), .spawn_corner(spawn_corner),
		.mybul_x(mybul_x), .mybul_y(mybul_y), .eny_x(eny_x), .eny_y(eny_y),
		.pv(pv.ctrl), .fv(fv.ctrl),
		.load(load), .advance(advance), .load_corner(load_corner),
		.eny_alive(eny_alive), .score(score)
	);

endmodule

// File: tb/tb_enemy_tank.sv
// enemy tank unit testbench
// applies a table of spawn, step, player, bullet and disable actions
// and compares the DUT against a behavioral model of the game rules
`timescale 1ns/1ps
`include "tank_macros.svh"

module tb_enemy_tank import tank_pkg::*; ();

	localparam int SETTLE = 3; // cycles after each action
	localparam int MAX_ROWS = 128;
	localparam int MAX_CYCLES = 4000; // whole-run budget
	localparam int SLOTS = `TANK_SHELL_SLOTS;
	localparam int X_MAX = `TANK_X_MAX;
	localparam int Y_MAX = `TANK_Y_MAX;
	localparam int UP = 0; // heading codes
	localparam int DOWN = 1;
	localparam int LEFT = 2;
	localparam int RIGHT = 3;
	localparam int ACT_SPAWN = 0; // table actions
	localparam int ACT_STEP = 1;
	localparam int ACT_PLAYER = 2;
	localparam int ACT_BULLET = 3;
	localparam int ACT_DISABLE = 4;

	logic clk;
	logic rst_n, enable, spawn, step, mybul_valid;
	logic [1:0] spawn_corner;
	coord_t my_x, my_y, mybul_x, mybul_y;
	coord_t eny_x, eny_y;
	dir_t eny_dir;
	logic eny_alive, player_hit;
	score_t score;
	credit_t shells_active;

	//--------------------------------------------------
	// stimulus table and predicted results
	//--------------------------------------------------
	string row_name [MAX_ROWS];
	int row_act [MAX_ROWS];
	int row_a [MAX_ROWS]; // corner or x
	int row_b [MAX_ROWS]; // y
	int exp_x [MAX_ROWS];
	int exp_y [MAX_ROWS];
	int exp_dir [MAX_ROWS];
	int exp_alive [MAX_ROWS];
	int exp_score [MAX_ROWS];
	int exp_shells [MAX_ROWS];
	int exp_hits [MAX_ROWS]; // running player_hit total
	int n_rows;

	int m_x, m_y, m_dir, m_alive, m_score, m_hits; // model enemy
	int p_x, p_y; // model player
	int s_busy [SLOTS]; // model shells
	int s_x [SLOTS];
	int s_y [SLOTS];
	int s_dir [SLOTS];
	int hit_count; // pulses seen on player_hit
	int cycles_run;
	int errors;

	enemy_tank_top i_enemy_tank_top
	(
		.clk(clk), .rst_n(rst_n), .enable(enable), .spawn(spawn), .step(step),
		.mybul_valid(mybul_valid), .spawn_corner(spawn_corner),
		.my_x(my_x), .my_y(my_y), .mybul_x(mybul_x), .mybul_y(mybul_y),
		.eny_x(eny_x), .eny_y(eny_y), .eny_dir(eny_dir), .eny_alive(eny_alive),
		.player_hit(player_hit), .score(score), .shells_active(shells_active)
	);

	always #2 clk = ~clk; // 4 ns period

	always @(posedge clk)
		if (player_hit)
			hit_count <= hit_count + 1;

	task automatic abort_run(input string why);
		errors++;
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic wait_cycles(input int n);
		int waited;
		waited = 0;
		while (waited < n)
		begin
			@(posedge clk);
			waited++;
			cycles_run++;
			if (cycles_run > MAX_CYCLES)
				abort_run("timeout, the run went past its cycle budget");
		end
	endtask

	task automatic check_value(input string test, input string what, input int exp, input int act);
		assert (exp == act)
		else
			abort_run($sformatf("Mismatch %s %s expected %0d actual %0d", test, what, exp, act));
	endtask

	task automatic add_row(input string name, input int act, input int a, input int b);
		if (n_rows >= MAX_ROWS)
			abort_run("stimulus table overflow");
		row_name[n_rows] = name;
		row_act[n_rows] = act;
		row_a[n_rows] = a;
		row_b[n_rows] = b;
		n_rows++;
	endtask

	//--------------------------------------------------
	// reference model
	//--------------------------------------------------
	function automatic int abs_diff(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	// returns 0 when the cell one move away lies off the field
	function automatic bit next_cell(input int x, input int y, input int d, output int nx,
		output int ny);
		nx = x;
		ny = y;
		case (d)
			UP: ny = y - 1;
			DOWN: ny = y + 1;
			LEFT: nx = x - 1;
			default: nx = x + 1;
		endcase
		return (nx >= 0) && (nx <= X_MAX) && (ny >= 0) && (ny <= Y_MAX);
	endfunction

	task automatic collision_check();
		if ((m_alive != 0) && (m_x == p_x) && (m_y == p_y))
		begin
			m_alive = 0; // rammed
			m_score = (m_score + 1) % (1 << `TANK_SCORE_W);
		end
	endtask

	task automatic predict_step();
		int i;
		int busy_before;
		int nx, ny, hd, vd, mdir;
		bit along_x;
		bit in_line;
		busy_before = 0;
		for (i = 0; i < SLOTS; i++)
			busy_before += s_busy[i]; // credits are counted before retires
		for (i = 0; i < SLOTS; i++)
			if (s_busy[i] != 0)
			begin
				if (!next_cell(s_x[i], s_y[i], s_dir[i], nx, ny))
					s_busy[i] = 0; // flies off without a hit
				else if ((nx == p_x) && (ny == p_y))
				begin
					s_busy[i] = 0;
					m_hits++;
				end
				else
				begin
					s_x[i] = nx;
					s_y[i] = ny;
				end
			end
		if (m_alive == 0)
			return;
		hd = abs_diff(m_x, p_x);
		vd = abs_diff(m_y, p_y);
		in_line = ((hd == 0) && (vd != 0)) || ((vd == 0) && (hd != 0));
		if (in_line && (busy_before < SLOTS))
			for (i = 0; i < SLOTS; i++)
				if (s_busy[i] == 0)
				begin
					s_busy[i] = 1; // shot from the cell before the move
					s_x[i] = m_x;
					s_y[i] = m_y;
					if (hd == 0)
						s_dir[i] = (p_y > m_y) ? DOWN : UP;
					else
						s_dir[i] = (p_x > m_x) ? RIGHT : LEFT;
					break;
				end
		if (hd == 0)
			along_x = 1'b0; // same column closes the row gap
		else if (vd == 0)
			along_x = 1'b1; // same row
		else
			along_x = (hd < vd); // smaller gap first
		if (along_x)
			mdir = (p_x > m_x) ? RIGHT : LEFT;
		else
			mdir = (p_y > m_y) ? DOWN : UP;
		m_dir = mdir;
		if (next_cell(m_x, m_y, mdir, nx, ny))
		begin
			m_x = nx;
			m_y = ny;
		end
		collision_check();
	endtask

	task automatic predict_rows();
		int i, j, busy;
		for (i = 0; i < n_rows; i++)
		begin
			case (row_act[i])
				ACT_SPAWN:
					if (m_alive == 0)
					begin
						m_x = (row_a[i] == 1 || row_a[i] == 3) ? X_MAX : 0;
						m_y = (row_a[i] >= 2) ? Y_MAX : 0;
						m_dir = UP;
						m_alive = 1;
						collision_check();
					end
				ACT_STEP:
					predict_step();
				ACT_PLAYER:
				begin
					p_x = row_a[i];
					p_y = row_b[i];
					collision_check();
				end
				ACT_BULLET:
					if ((m_alive != 0) && (row_a[i] == m_x) && (row_b[i] == m_y))
					begin
						m_alive = 0;
						m_score = (m_score + 1) % (1 << `TANK_SCORE_W);
					end
				default:
				begin
					m_alive = 0; // enable low clears the unit
					m_score = 0;
					for (j = 0; j < SLOTS; j++)
						s_busy[j] = 0;
				end
			endcase
			busy = 0;
			for (j = 0; j < SLOTS; j++)
				busy += s_busy[j];
			exp_x[i] = m_x;
			exp_y[i] = m_y;
			exp_dir[i] = m_dir;
			exp_alive[i] = m_alive;
			exp_score[i] = m_score;
			exp_shells[i] = busy;
			exp_hits[i] = m_hits;
		end
	endtask

	//--------------------------------------------------
	// apply one row and compare
	//--------------------------------------------------
	task automatic apply_row(input int i);
		wait_cycles(1);
		case (row_act[i])
			ACT_SPAWN:
			begin
				spawn <= 1'b1;
				spawn_corner <= 2'(row_a[i]);
			end
			ACT_STEP:
				step <= 1'b1;
			ACT_PLAYER:
			begin
				my_x <= coord_t'(row_a[i]);
				my_y <= coord_t'(row_b[i]);
			end
			ACT_BULLET:
			begin
				mybul_valid <= 1'b1;
				mybul_x <= coord_t'(row_a[i]);
				mybul_y <= coord_t'(row_b[i]);
			end
			default:
				enable <= 1'b0;
		endcase
		wait_cycles(1);
		spawn <= 1'b0; // every pulse lasts one cycle
		step <= 1'b0;
		mybul_valid <= 1'b0;
		enable <= 1'b1;
		wait_cycles(SETTLE);
		@(negedge clk);
		check_value(row_name[i], "eny_alive", exp_alive[i], int'(eny_alive));
		check_value(row_name[i], "score", exp_score[i], int'(score));
		check_value(row_name[i], "shells_active", exp_shells[i], int'(shells_active));
		check_value(row_name[i], "player_hit count", exp_hits[i], hit_count);
		if (exp_alive[i] != 0)
		begin
			check_value(row_name[i], "eny_x", exp_x[i], int'(eny_x));
			check_value(row_name[i], "eny_y", exp_y[i], int'(eny_y));
			check_value(row_name[i], "eny_dir", exp_dir[i], int'(eny_dir));
		end
	endtask

	initial
	begin
		int k;
		clk = 1'b0;
		rst_n = 1'b0;
		enable = 1'b1;
		spawn = 1'b0;
		step = 1'b0;
		mybul_valid = 1'b0;
		spawn_corner = 2'd0;
		my_x = coord_t'(12); // player starts mid field
		my_y = coord_t'(6);
		mybul_x = '0;
		mybul_y = '0;
		hit_count = 0;
		cycles_run = 0;
		errors = 0;
		n_rows = 0;
		m_x = 0;
		m_y = 0;
		m_dir = UP;
		m_alive = 0;
		m_score = 0;
		m_hits = 0;
		p_x = 12;
		p_y = 6;
		for (k = 0; k < SLOTS; k++)
			s_busy[k] = 0;
		void'($urandom(32'ha153));

		// corners, bullet kills and respawn
		add_row("spawn_c0", ACT_SPAWN, 0, 0);
		add_row("bullet_miss", ACT_BULLET, 5, 5);
		add_row("bullet_kill_c0", ACT_BULLET, 0, 0);
		add_row("spawn_c1", ACT_SPAWN, 1, 0);
		add_row("bullet_kill_c1", ACT_BULLET, X_MAX, 0);
		add_row("spawn_c2", ACT_SPAWN, 2, 0);
		add_row("bullet_kill_c2", ACT_BULLET, 0, Y_MAX);
		add_row("spawn_c3", ACT_SPAWN, 3, 0);
		add_row("spawn_while_alive", ACT_SPAWN, 0, 0);
		// up the edge, two shots, credit stall, ram and double strike
		for (k = 0; k < 20; k++)
			add_row($sformatf("pursuit_step_%0d", k), ACT_STEP, 0, 0);
		add_row("respawn_c0", ACT_SPAWN, 0, 0);
		add_row("player_in_column", ACT_PLAYER, 0, 6);
		for (k = 0; k < 2; k++)
			add_row($sformatf("column_step_%0d", k), ACT_STEP, 0, 0);
		add_row("player_away", ACT_PLAYER, 10, 3);
		for (k = 0; k < 14; k++)
			add_row($sformatf("exit_step_%0d", k), ACT_STEP, 0, 0); // shells leave the field
		add_row("spawn_c2_again", ACT_SPAWN, 2, 0);
		add_row("player_rams", ACT_PLAYER, 0, Y_MAX);
		add_row("spawn_c1_again", ACT_SPAWN, 1, 0);
		// live tank with a shell in flight when enable drops
		add_row("player_below_c1", ACT_PLAYER, X_MAX, 6);
		add_row("fire_before_clear", ACT_STEP, 0, 0);
		add_row("disable_in_flight", ACT_DISABLE, 0, 0);
		add_row("spawn_c1_after_clear", ACT_SPAWN, 1, 0);
		for (k = 0; k < 6; k++)
		begin
			add_row($sformatf("random_spawn_%0d", k), ACT_SPAWN, $urandom % 4, 0);
			add_row($sformatf("random_player_%0d", k), ACT_PLAYER,
				$urandom % (X_MAX + 1), $urandom % (Y_MAX + 1));
			add_row($sformatf("random_step_a_%0d", k), ACT_STEP, 0, 0);
			add_row($sformatf("random_step_b_%0d", k), ACT_STEP, 0, 0);
		end
		add_row("disable", ACT_DISABLE, 0, 0);
		add_row("spawn_after_clear", ACT_SPAWN, 3, 0);
		predict_rows();

		wait_cycles(4); // reset held 4 cycles
		rst_n <= 1'b1;
		wait_cycles(2);
		@(negedge clk);
		check_value("reset", "eny_alive", 0, int'(eny_alive));
		check_value("reset", "score", 0, int'(score));
		check_value("reset", "shells_active", 0, int'(shells_active));
		for (k = 0; k < n_rows; k++)
			apply_row(k);

		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: sim.f
+incdir+verilog
verilog/tank_pkg.sv
verilog/tank_ifs.sv
verilog/pursuit_calc.sv
verilog/tank_mover.sv
verilog/shell_engine.sv
verilog/enemy_ctrl.sv
verilog/enemy_tank_top.sv
tb/tb_enemy_tank.sv

// File: Makefile
# enemy tank unit, Verilator build and run
SIM := verilator
TOP := tb_enemy_tank
FILELIST := sim.f
SIM_FLAGS := --binary --timing --assert -Wno-fatal
BUILD_DIR := obj_dir
LOG := sim.log
PASS_TEXT := No errors

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verilog/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
